// ==== list.f ====
+incdir+test
logic/ppc_fx_pkg.sv
logic/gpr_file.sv
logic/instr_issue.sv
logic/reservation_station.sv
logic/fx_unit.sv
logic/result_arbiter.sv
logic/ppc_fx_core.sv
test/clk_gen.sv
test/tb_ppc_fx_core.sv

// ==== Bender.yml ====
package:
  name: ppc_fx_core

sources:
  - files:
      - logic/ppc_fx_pkg.sv
      - logic/gpr_file.sv
      - logic/instr_issue.sv
      - logic/reservation_station.sv
      - logic/fx_unit.sv
      - logic/result_arbiter.sv
      - logic/ppc_fx_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/clk_gen.sv
      - test/tb_ppc_fx_core.sv

// ==== test/tb_model.svh ====
//--------------------
// Testbench model
// Instruction encoders, in-order GPR model, expected results, LFSR
//--------------------
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    gpr_addr_t dst;
    word_t     value;
} exp_t;

localparam logic [31:0] LFSR_TAPS = 32'h80200003;

word_t       gpr_m [NUM_GPRS] = '{default: '0};
exp_t        expected [$];
int          push_count = 0;
logic [31:0] lfsr_state = 32'd9;

function automatic void expect_result(gpr_addr_t dst, word_t value);
    exp_t e;
    e.dst   = dst;
    e.value = value;
    expected.push_back(e);
    push_count++;
endfunction

// Galois LFSR stepped once per bit
function automatic word_t lfsr_bits(int n);
    word_t r;
    logic  out;
    r = '0;
    for (int i = 0; i < n; i++) begin
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        r = {r[1:31], out};
    end
    return r;
endfunction

//--------------------
// Encoders that also step the model
//--------------------
function automatic word_t addi_word(gpr_addr_t rd, gpr_addr_t ra, logic [0:15] simm);
    word_t a;
    a         = (ra == 5'd0) ? '0 : gpr_m[ra];
    gpr_m[rd] = a + {{16{simm[0]}}, simm};
    expect_result(rd, gpr_m[rd]);
    return {OPC_ADDI, rd, ra, simm};
endfunction

// rA = rS | uimm
function automatic word_t ori_word(gpr_addr_t ra, gpr_addr_t rs, logic [0:15] uimm);
    gpr_m[ra] = gpr_m[rs] | {16'h0000, uimm};
    expect_result(ra, gpr_m[ra]);
    return {OPC_ORI, rs, ra, uimm};
endfunction

// Add and subf write rD and take rA as the first source
// Logical forms write rA and take rS as the first source
function automatic word_t xform_word(logic [0:9] xo, gpr_addr_t dst, gpr_addr_t src1,
                                     gpr_addr_t src2);
    word_t a;
    word_t b;
    word_t v;
    a = gpr_m[src1];
    b = gpr_m[src2];
    case (xo)
        XO_ADD:  v = a + b;
        XO_SUBF: v = b - a;
        XO_AND:  v = a & b;
        XO_OR:   v = a | b;
        default: v = a ^ b;
    endcase
    gpr_m[dst] = v;
    expect_result(dst, v);
    if (xo == XO_ADD || xo == XO_SUBF) begin
        return {OPC_X, dst, src1, src2, xo, 1'b0};
    end
    return {OPC_X, src1, dst, src2, xo, 1'b0};
endfunction

`endif

// ==== test/tb_ppc_fx_core.sv ====
`timescale 1ns/1ps
//--------------------
// Testbench for the fixed-point core
// Directed tests checked against an in-order register model
//--------------------
module tb_ppc_fx_core
    import ppc_fx_pkg::*;
;

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_INSTRS     = 52;
    localparam int TIMEOUT_CYCLES = NUM_INSTRS * 20 + 200;
    localparam int STALL_LIMIT    = 200;

    logic    clk;
    logic    arst_n;
    logic    instr_valid;
    logic    instr_ready;
    word_t   instr;
    logic    wb_valid;
    result_t wb;

    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   wb_count = 0;
    int                   last_stall = 0;
    logic [0:NUM_UNITS-1] units_seen = '0;

    `include "tb_model.svh"

    clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) clocks (.clk(clk), .arst_n(arst_n));

    ppc_fx_core dut (
        .clk(clk),
        .arst_n(arst_n),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    //--------------------
    // Write-back monitor
    //--------------------
    always @(negedge clk) begin : wb_monitor
        int idx;
        if (arst_n === 1'b1 && wb_valid === 1'b1) begin
            idx = -1;
            wb_count++;
            units_seen[int'(wb.tag) / RS_DEPTH] = 1'b1;
            for (int i = 0; i < expected.size(); i++) begin
                if (idx < 0 && expected[i].dst == wb.dst && expected[i].value == wb.value) begin
                    idx = i;
                end
            end
            assert (idx >= 0) else begin
                $display("mismatch wb dst=%h value=%h", wb.dst, wb.value);
                errors++;
            end
            if (idx >= 0) begin
                expected.delete(idx);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    task automatic send_instr(input word_t w);
        int waited;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        while (!instr_ready && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        last_stall = waited;
        assert (instr_ready) else begin
            $display("instruction %h was never accepted", w);
            errors++;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic drain_results(input string name);
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < STALL_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (expected.size() == 0) else begin
            $display("%s: %0d results never arrived", name, expected.size());
            foreach (expected[i]) begin
                $display("  missing write of r%0d = %h", expected[i].dst, expected[i].value);
            end
            errors++;
        end
        expected.delete();
        assert (wb_count == push_count) else begin
            $display("%s: %0d write-backs seen for %0d instructions", name, wb_count,
                     push_count);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - err0);
        end
    endtask

    task automatic check_idle();
        assert (wb_valid === 1'b0) else begin
            $display("mismatch wb_valid got %h expected 0", wb_valid);
            errors++;
        end
        assert (instr_ready === 1'b1) else begin
            $display("mismatch instr_ready got %h expected 1", instr_ready);
            errors++;
        end
    endtask

    //--------------------
    // Directed tests
    //--------------------
    task automatic check_reset();
        int err0;
        err0 = errors;
        @(posedge clk);
        @(negedge clk);
        while (!arst_n) begin
            check_idle();
            @(negedge clk);
        end
        check_idle();
        @(posedge clk);
        #1;
        finish_test("reset", err0);
    endtask

    task automatic immediates();
        int err0;
        err0 = errors;
        send_instr(addi_word(5'd1, 5'd0, 16'hFFFF));
        send_instr(addi_word(5'd2, 5'd0, 16'h8000));
        send_instr(addi_word(5'd3, 5'd0, 16'h7FFF));
        send_instr(ori_word(5'd4, 5'd2, 16'hABCD));
        send_instr(ori_word(5'd5, 5'd0, 16'h8000));
        send_instr(addi_word(5'd6, 5'd1, 16'hFFFE));
        drain_results("immediates");
        finish_test("immediates", err0);
    endtask

    task automatic dependency_chain();
        int err0;
        err0 = errors;
        send_instr(addi_word(5'd10, 5'd0, 16'h04D2));
        send_instr(addi_word(5'd11, 5'd0, 16'hFFB3));
        send_instr(xform_word(XO_ADD, 5'd12, 5'd10, 5'd11));
        send_instr(xform_word(XO_SUBF, 5'd13, 5'd12, 5'd10));
        send_instr(xform_word(XO_SUBF, 5'd14, 5'd11, 5'd13));
        send_instr(xform_word(XO_ADD, 5'd15, 5'd14, 5'd12));
        send_instr(xform_word(XO_SUBF, 5'd12, 5'd15, 5'd13));
        send_instr(xform_word(XO_ADD, 5'd16, 5'd12, 5'd15));
        drain_results("dependency chain");
        finish_test("dependency chain", err0);
    endtask

    task automatic logical_mix();
        int         err0;
        logic [0:9] xo;
        err0       = errors;
        units_seen = '0;
        for (int r = 20; r < 24; r++) begin
            send_instr(addi_word(gpr_addr_t'(r), 5'd0, 16'(lfsr_bits(16))));
            send_instr(ori_word(gpr_addr_t'(r), gpr_addr_t'(r), 16'(lfsr_bits(16))));
        end
        for (int k = 0; k < 12; k++) begin
            xo = (k % 3 == 0) ? XO_AND : (k % 3 == 1) ? XO_OR : XO_XOR;
            send_instr(xform_word(xo, gpr_addr_t'(24 + k % 8), gpr_addr_t'(20 + lfsr_bits(3)),
                                  gpr_addr_t'(20 + lfsr_bits(3))));
        end
        drain_results("logical mix");
        assert (units_seen == '1) else begin
            $display("logical mix results did not come from both units");
            errors++;
        end
        finish_test("logical mix", err0);
    endtask

    // Twelve back-to-back writes and reads around r7
    task automatic waw_pipeline();
        int err0;
        err0 = errors;
        send_instr(addi_word(5'd7, 5'd0, 16'h0003));
        send_instr(xform_word(XO_ADD, 5'd8, 5'd7, 5'd7));
        send_instr(addi_word(5'd7, 5'd7, 16'h0064));
        send_instr(xform_word(XO_SUBF, 5'd9, 5'd8, 5'd7));
        send_instr(xform_word(XO_XOR, 5'd7, 5'd7, 5'd9));
        send_instr(xform_word(XO_ADD, 5'd17, 5'd7, 5'd8));
        send_instr(addi_word(5'd7, 5'd17, 16'hFFFB));
        send_instr(xform_word(XO_OR, 5'd18, 5'd7, 5'd9));
        send_instr(xform_word(XO_SUBF, 5'd7, 5'd18, 5'd7));
        send_instr(xform_word(XO_AND, 5'd19, 5'd7, 5'd17));
        send_instr(xform_word(XO_ADD, 5'd7, 5'd7, 5'd19));
        send_instr(ori_word(5'd7, 5'd7, 16'h00F0));
        drain_results("write after write");
        finish_test("write after write", err0);
    endtask

    task automatic unsupported_encoding();
        int err0;
        err0 = errors;
        send_instr({6'd1, 26'h0000ABC});
        assert (last_stall == 0) else begin
            $display("unknown opcode was not taken at once");
            errors++;
        end
        send_instr({OPC_X, 5'd3, 5'd1, 5'd2, 10'd0, 1'b0});
        send_instr({OPC_X, 5'd3, 5'd1, 5'd2, XO_ADD, 1'b1});
        send_instr(xform_word(XO_ADD, 5'd3, 5'd1, 5'd2));
        send_instr(addi_word(5'd4, 5'd3, 16'h0009));
        send_instr(xform_word(XO_XOR, 5'd5, 5'd4, 5'd1));
        drain_results("unsupported encoding");
        // Bus stays quiet once the last result is in
        repeat (8) @(posedge clk);
        assert (wb_count == push_count) else begin
            $display("extra write-backs after the unsupported encodings");
            errors++;
        end
        finish_test("unsupported encoding", err0);
    endtask

    initial begin
        instr_valid = 1'b0;
        instr       = {OPC_ADDI, 26'h0000000};
        check_reset();
        immediates();
        dependency_chain();
        logical_mix();
        waw_pipeline();
        unsupported_encoding();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps
//--------------------
// Testbench clock and reset
//--------------------
module clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
)(
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== logic/ppc_fx_core.sv ====
`timescale 1ns/1ps
//--------------------
// Out-of-order fixed-point core
// Issue, renamed GPRs, two station/unit pairs and one result bus
//--------------------
module ppc_fx_core
    import ppc_fx_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    instr_valid,
    output logic    instr_ready,
    input  word_t   instr,
    output logic    wb_valid,
    output result_t wb
);

    logic [0:NUM_UNITS-1] disp_valid;
    dispatch_t            disp;
    logic [0:NUM_UNITS-1] rs_free;
    rs_slot_t             rs_free_slot [NUM_UNITS];

    gpr_addr_t rd_addr_a;
    gpr_addr_t rd_addr_b;
    operand_t  rd_a;
    operand_t  rd_b;
    logic      rename_en;
    gpr_addr_t rename_addr;
    rs_tag_t   rename_tag;

    // Station to unit
    logic [0:NUM_UNITS-1] iss_valid;
    logic [0:NUM_UNITS-1] iss_ready;
    fx_op_e               iss_op  [NUM_UNITS];
    gpr_addr_t            iss_dst [NUM_UNITS];
    rs_tag_t              iss_tag [NUM_UNITS];
    word_t                iss_a   [NUM_UNITS];
    word_t                iss_b   [NUM_UNITS];

    // Unit to arbiter
    logic [0:NUM_UNITS-1] res_valid;
    logic [0:NUM_UNITS-1] res_ready;
    result_t              res [NUM_UNITS];

    instr_issue issue (
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr(instr),
        .rs_free(rs_free),
        .rs_free_slot(rs_free_slot),
        .disp_valid(disp_valid),
        .disp(disp),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_a(rd_a),
        .rd_b(rd_b),
        .rename_en(rename_en),
        .rename_addr(rename_addr),
        .rename_tag(rename_tag)
    );

    gpr_file gprs (
        .clk(clk),
        .arst_n(arst_n),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_a(rd_a),
        .rd_b(rd_b),
        .rename_en(rename_en),
        .rename_addr(rename_addr),
        .rename_tag(rename_tag),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        reservation_station #(
            .UNIT_INDEX(u)
        ) rs (
            .clk(clk),
            .arst_n(arst_n),
            .disp_valid(disp_valid[u]),
            .disp(disp),
            .free(rs_free[u]),
            .free_slot(rs_free_slot[u]),
            .iss_valid(iss_valid[u]),
            .iss_ready(iss_ready[u]),
            .iss_op(iss_op[u]),
            .iss_dst(iss_dst[u]),
            .iss_tag(iss_tag[u]),
            .iss_a(iss_a[u]),
            .iss_b(iss_b[u]),
            .wb_valid(wb_valid),
            .wb(wb)
        );

        fx_unit fx (
            .clk(clk),
            .arst_n(arst_n),
            .iss_valid(iss_valid[u]),
            .iss_ready(iss_ready[u]),
            .iss_op(iss_op[u]),
            .iss_dst(iss_dst[u]),
            .iss_tag(iss_tag[u]),
            .iss_a(iss_a[u]),
            .iss_b(iss_b[u]),
            .res_valid(res_valid[u]),
            .res_ready(res_ready[u]),
            .res(res[u])
        );
    end

    result_arbiter arbiter (
        .clk(clk),
        .arst_n(arst_n),
        .req_valid(res_valid),
        .req_ready(res_ready),
        .req(res),
        .wb_valid(wb_valid),
        .wb(wb)
    );

endmodule

// ==== logic/result_arbiter.sv ====
`timescale 1ns/1ps
//--------------------
// Write-back arbiter
// Round-robin pick of one unit result per cycle onto the result bus
//--------------------
module result_arbiter
    import ppc_fx_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [0:NUM_UNITS-1] req_valid,
    output logic [0:NUM_UNITS-1] req_ready,
    input  result_t              req [NUM_UNITS],
    output logic                 wb_valid,
    output result_t              wb
);

    unit_idx_t ptr;
    unit_idx_t grant_idx;
    logic      grant;

    // First requester at or after the pointer
    always_comb begin
        int idx;
        grant     = 1'b0;
        grant_idx = ptr;
        for (int k = 0; k < NUM_UNITS; k++) begin
            idx = (int'(ptr) + k) % NUM_UNITS;
            if (!grant && req_valid[idx]) begin
                grant     = 1'b1;
                grant_idx = unit_idx_t'(idx);
            end
        end
        req_ready            = '0;
        req_ready[grant_idx] = grant;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            ptr      <= '0;
        end else begin
            wb_valid <= grant;
            if (grant) begin
                ptr <= unit_idx_t'((int'(grant_idx) + 1) % NUM_UNITS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            wb <= req[grant_idx];
        end
    end

endmodule

// ==== logic/fx_unit.sv ====
`timescale 1ns/1ps
//--------------------
// Fixed-point execution unit
// Add, subtract-from and logical ops into one output register
//--------------------
module fx_unit
    import ppc_fx_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      iss_valid,
    output logic      iss_ready,
    input  fx_op_e    iss_op,
    input  gpr_addr_t iss_dst,
    input  rs_tag_t   iss_tag,
    input  word_t     iss_a,
    input  word_t     iss_b,
    output logic      res_valid,
    input  logic      res_ready,
    output result_t   res
);

    word_t value;

    always_comb begin
        case (iss_op)
            FX_ADD:  value = iss_a + iss_b;
            FX_SUBF: value = iss_b - iss_a;
            FX_AND:  value = iss_a & iss_b;
            FX_OR:   value = iss_a | iss_b;
            FX_XOR:  value = iss_a ^ iss_b;
            default: value = '0;
        endcase
    end

    // Accept when empty or draining this cycle
    assign iss_ready = !res_valid || res_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (iss_ready) begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            res.tag   <= iss_tag;
            res.dst   <= iss_dst;
            res.value <= value;
        end
    end

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
//--------------------
// Reservation station
// Entries wait for operands on the result bus and issue to one unit
// An entry is held until its own tag is written back
//--------------------
module reservation_station
    import ppc_fx_pkg::*;
#(
    parameter int UNIT_INDEX = 0
)(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      disp_valid,
    input  dispatch_t disp,
    output logic      free,
    output rs_slot_t  free_slot,
    output logic      iss_valid,
    input  logic      iss_ready,
    output fx_op_e    iss_op,
    output gpr_addr_t iss_dst,
    output rs_tag_t   iss_tag,
    output word_t     iss_a,
    output word_t     iss_b,
    input  logic      wb_valid,
    input  result_t   wb
);

    typedef enum logic [0:1] {
        ENT_FREE,
        ENT_WAIT,
        ENT_FLIGHT
    } ent_state_e;

    ent_state_e state [RS_DEPTH];
    dispatch_t  entry [RS_DEPTH];
    rs_slot_t   iss_slot;

    function automatic rs_tag_t slot_tag(int slot);
        return rs_tag_t'(UNIT_INDEX * RS_DEPTH + slot);
    endfunction

    // Scan downwards so the lowest index wins
    always_comb begin
        free      = 1'b0;
        free_slot = '0;
        iss_valid = 1'b0;
        iss_slot  = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == ENT_FREE) begin
                free      = 1'b1;
                free_slot = rs_slot_t'(i);
            end
            if (state[i] == ENT_WAIT && entry[i].a.ready && entry[i].b.ready) begin
                iss_valid = 1'b1;
                iss_slot  = rs_slot_t'(i);
            end
        end
    end

    assign iss_op  = entry[iss_slot].op;
    assign iss_dst = entry[iss_slot].dst;
    assign iss_tag = slot_tag(int'(iss_slot));
    assign iss_a   = entry[iss_slot].a.value;
    assign iss_b   = entry[iss_slot].b.value;

    //--------------------
    // Entry state
    //--------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state[i] <= ENT_FREE;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case (state[i])
                    ENT_FREE: begin
                        if (disp_valid && free_slot == rs_slot_t'(i)) begin
                            state[i] <= ENT_WAIT;
                        end
                    end
                    ENT_WAIT: begin
                        if (iss_valid && iss_ready && iss_slot == rs_slot_t'(i)) begin
                            state[i] <= ENT_FLIGHT;
                        end
                    end
                    ENT_FLIGHT: begin
                        if (wb_valid && wb.tag == slot_tag(i)) begin
                            state[i] <= ENT_FREE;
                        end
                    end
                    default: state[i] <= ENT_FREE;
                endcase
            end
        end
    end

    // Operand capture from the bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (state[i] == ENT_FREE && disp_valid && free_slot == rs_slot_t'(i)) begin
                entry[i] <= disp;
            end else if (state[i] == ENT_WAIT && wb_valid) begin
                if (!entry[i].a.ready && entry[i].a.tag == wb.tag) begin
                    entry[i].a.ready <= 1'b1;
                    entry[i].a.value <= wb.value;
                end
                if (!entry[i].b.ready && entry[i].b.tag == wb.tag) begin
                    entry[i].b.ready <= 1'b1;
                    entry[i].b.value <= wb.value;
                end
            end
        end
    end

endmodule

// ==== logic/instr_issue.sv ====
`timescale 1ns/1ps
//--------------------
// Decode and dispatch
// Reads operands, picks the first station with room and renames rD/rA
//--------------------
module instr_issue
    import ppc_fx_pkg::*;
(
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  word_t                instr,
    input  logic [0:NUM_UNITS-1] rs_free,
    input  rs_slot_t             rs_free_slot [NUM_UNITS],
    output logic [0:NUM_UNITS-1] disp_valid,
    output dispatch_t            disp,
    output gpr_addr_t            rd_addr_a,
    output gpr_addr_t            rd_addr_b,
    input  operand_t             rd_a,
    input  operand_t             rd_b,
    output logic                 rename_en,
    output gpr_addr_t            rename_addr,
    output rs_tag_t              rename_tag
);

    logic [0:5]  opcd;
    logic [0:9]  xo;
    logic [0:15] imm;
    gpr_addr_t   f_rt;
    gpr_addr_t   f_ra;
    gpr_addr_t   f_rb;
    logic        supported;
    logic        any_free;
    unit_idx_t   unit_sel;

    function automatic operand_t const_op(word_t v);
        operand_t op;
        op.ready = 1'b1;
        op.tag   = '0;
        op.value = v;
        return op;
    endfunction

    assign opcd = instr[0:5];
    assign f_rt = instr[6:10];
    assign f_ra = instr[11:15];
    assign f_rb = instr[16:20];
    assign xo   = instr[21:30];
    assign imm  = instr[16:31];

    //--------------------
    // Decode
    //--------------------
    always_comb begin
        supported = 1'b1;
        disp.op   = FX_ADD;
        disp.dst  = f_rt;
        disp.a    = rd_a;
        disp.b    = rd_b;
        rd_addr_a = f_ra;
        rd_addr_b = f_rb;
        case (opcd)
            OPC_ADDI: begin
                disp.b = const_op({{16{imm[0]}}, imm});
                if (f_ra == '0) begin
                    disp.a = const_op('0);
                end
            end
            OPC_ORI: begin
                disp.op   = FX_OR;
                disp.dst  = f_ra;
                rd_addr_a = f_rt;
                disp.b    = const_op({16'h0000, imm});
            end
            OPC_X: begin
                case (xo)
                    XO_ADD:  disp.op = FX_ADD;
                    XO_SUBF: disp.op = FX_SUBF;
                    XO_AND:  disp.op = FX_AND;
                    XO_OR:   disp.op = FX_OR;
                    XO_XOR:  disp.op = FX_XOR;
                    default: supported = 1'b0;
                endcase
                // Logical forms read rS and write rA
                if (xo == XO_AND || xo == XO_OR || xo == XO_XOR) begin
                    rd_addr_a = f_rt;
                    disp.dst  = f_ra;
                end
                // No record forms
                if (instr[31]) begin
                    supported = 1'b0;
                end
            end
            default: supported = 1'b0;
        endcase
    end

    //--------------------
    // Station select
    //--------------------
    always_comb begin
        any_free = 1'b0;
        unit_sel = '0;
        for (int u = NUM_UNITS - 1; u >= 0; u--) begin
            if (rs_free[u]) begin
                any_free = 1'b1;
                unit_sel = unit_idx_t'(u);
            end
        end
    end

    // Unsupported words are taken and dropped
    assign instr_ready = any_free || !supported;
    assign rename_en   = instr_valid && supported && any_free;
    assign rename_addr = disp.dst;
    assign rename_tag  = rs_tag_t'(int'(unit_sel) * RS_DEPTH + int'(rs_free_slot[unit_sel]));

    always_comb begin
        disp_valid           = '0;
        disp_valid[unit_sel] = rename_en;
    end

endmodule

// ==== logic/gpr_file.sv ====
`timescale 1ns/1ps
//--------------------
// General-purpose register file
// Registers hold a value or wait on a station tag
// Results on the write-back bus are forwarded to the read ports
//--------------------
module gpr_file
    import ppc_fx_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  gpr_addr_t rd_addr_a,
    input  gpr_addr_t rd_addr_b,
    output operand_t  rd_a,
    output operand_t  rd_b,
    input  logic      rename_en,
    input  gpr_addr_t rename_addr,
    input  rs_tag_t   rename_tag,
    input  logic      wb_valid,
    input  result_t   wb
);

    word_t               value [NUM_GPRS];
    rs_tag_t             tag   [NUM_GPRS];
    logic [0:NUM_GPRS-1] busy;
    logic                wb_hit;

    function automatic operand_t read_reg(gpr_addr_t addr);
        operand_t op;
        op.ready = ~busy[addr];
        op.tag   = tag[addr];
        op.value = value[addr];
        // Producer delivering right now
        if (busy[addr] && wb_valid && wb.tag == tag[addr]) begin
            op.ready = 1'b1;
            op.value = wb.value;
        end
        return op;
    endfunction

    always_comb begin
        rd_a = read_reg(rd_addr_a);
        rd_b = read_reg(rd_addr_b);
    end

    // Only the latest producer of a register may update it
    assign wb_hit = wb_valid && busy[wb.dst] && tag[wb.dst] == wb.tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            for (int i = 0; i < NUM_GPRS; i++) begin
                value[i] <= '0;
                tag[i]   <= '0;
            end
        end else begin
            if (wb_hit) begin
                value[wb.dst] <= wb.value;
                busy[wb.dst]  <= 1'b0;
            end
            // Rename wins over a write-back to the same register
            if (rename_en) begin
                busy[rename_addr] <= 1'b1;
                tag[rename_addr]  <= rename_tag;
            end
        end
    end

endmodule

// ==== logic/ppc_fx_pkg.sv ====
//--------------------
// Fixed-point core definitions
// Widths, tags, encodings and the bus structs shared by all blocks
//--------------------
package ppc_fx_pkg;

    localparam int NUM_UNITS = 2;
    localparam int RS_DEPTH  = 4;
    localparam int NUM_GPRS  = 32;

    typedef logic [0:31] word_t;
    typedef logic [0:4]  gpr_addr_t;
    typedef logic [0:$clog2(NUM_UNITS*RS_DEPTH)-1] rs_tag_t;
    typedef logic [0:$clog2(RS_DEPTH)-1]           rs_slot_t;
    typedef logic [0:$clog2(NUM_UNITS)-1]          unit_idx_t;

    //--------------------
    // Primary and extended opcodes
    //--------------------
    localparam logic [0:5] OPC_ADDI = 6'd14;
    localparam logic [0:5] OPC_ORI  = 6'd24;
    localparam logic [0:5] OPC_X    = 6'd31;

    localparam logic [0:9] XO_ADD  = 10'd266;
    localparam logic [0:9] XO_SUBF = 10'd40;
    localparam logic [0:9] XO_AND  = 10'd28;
    localparam logic [0:9] XO_OR   = 10'd444;
    localparam logic [0:9] XO_XOR  = 10'd316;

    typedef enum logic [0:2] {
        FX_ADD,
        FX_SUBF,
        FX_AND,
        FX_OR,
        FX_XOR
    } fx_op_e;

    // Value is valid when ready, otherwise wait for tag
    typedef struct packed {
        logic    ready;
        rs_tag_t tag;
        word_t   value;
    } operand_t;

    typedef struct packed {
        fx_op_e    op;
        gpr_addr_t dst;
        operand_t  a;
        operand_t  b;
    } dispatch_t;

    typedef struct packed {
        rs_tag_t   tag;
        gpr_addr_t dst;
        word_t     value;
    } result_t;

endpackage
